// ==== verification/mini_core_trace.txt ====
# W reg data : register write | I instr : instruction word (hex)
# R a b y : expected result | T name : start of a test
T reset_add
I 6CA
R 0 0 0
T add_chain
W 1 5
W 2 7
I 6CA
R 5 7 C
# r4 = r3 + r1 reads the previous sum
I 719
R C 5 1
W 5 F
W 6 9
I 7EE
R F 9 8
T sub_wrap
I 411
R 7 5 2
I 4CA
R 5 7 E
W 1 0
W 2 1
I 50A
R 0 1 F
T load_store
W 6 A
I 263
I 053
I 7E9
R A 0 A
W 2 6
I 22C
I 03C
I 043
I 61C
R 6 A 0
# untouched address reads zero
I 027
I 656
R 0 A A
T undefined_ops
W 3 3
W 4 9
I 8DC
I B1C
I CE3
I F23
I 75C
R 3 9 C
I 063
I 7F0
R A 0 A
T back_pressure
W 0 1
W 1 2
W 2 3
W 3 4
I 701
R 1 2 3
I 764
R 3 3 6
I 585
R 1 6 B
I 7F3
R B 4 F
I 43A
R F 3 C
I 67F
R F F E
I 488
R E C 2
I 6D6
R 2 B D

// ==== project.f ====
logic/isa_pkg.sv
logic/core_pkg.sv
logic/sequencer.sv
logic/register_file.sv
logic/alu.sv
logic/data_memory.sv
logic/mini_core.sv
verification/mini_core_tb.sv

// ==== Bender.yml ====
package:
  name: mini_core

sources:
  # packages before the modules that import them
  - files:
      - logic/isa_pkg.sv
      - logic/core_pkg.sv
      - logic/sequencer.sv
      - logic/register_file.sv
      - logic/alu.sv
      - logic/data_memory.sv
      - logic/mini_core.sv
  - target: test
    files:
      - verification/mini_core_tb.sv

// ==== verification/mini_core_tb.sv ====
`timescale 1ns/10ps

module mini_core_tb;
    import isa_pkg::*;
    import core_pkg::*;

    localparam int    HALF_PERIOD     = 50;
    localparam int    RESET_CYCLES    = 16;
    localparam int    CYCLES_PER_LINE = 60;
    localparam string TRACE_FILE      = "verification/mini_core_trace.txt";

    logic    clk;
    logic    rst;
    cmd_t    cmd;
    logic    cmd_valid;
    logic    cmd_ready;
    result_t res;
    logic    res_valid;
    logic    res_ready;

    // parsed trace with one entry per item line
    byte     tr_kind [$];
    int      tr_f0 [$];
    int      tr_f1 [$];
    int      tr_f2 [$];
    string   tr_name [$];
    result_t exp_q [$];

    logic    trace_loaded = 1'b0;
    int      n_lines = 0;
    int      n_tests = 0;
    int      n_checks = 0;
    int      n_errors = 0;
    int      test_err_start = 0;
    int      limit_cycles;
    string   cur_test = "";
    result_t mon_exp;

    mini_core i_mini_core (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .res       (res),
        .res_valid (res_valid),
        .res_ready (res_ready)
    );

    always #(HALF_PERIOD) clk = ~clk;

    task automatic check_result(input result_t got, input result_t exp);
        n_checks++;
        if (got.a !== exp.a) begin
            $display("MISMATCH @ %0t: operand a is %h, expected %h", $time, got.a, exp.a);
            n_errors++;
        end
        if (got.b !== exp.b) begin
            $display("MISMATCH @ %0t: operand b is %h, expected %h", $time, got.b, exp.b);
            n_errors++;
        end
        if (got.y !== exp.y) begin
            $display("MISMATCH @ %0t: result y is %h, expected %h", $time, got.y, exp.y);
            n_errors++;
        end
    endtask

    task automatic load_trace();
        int    fd;
        int    f0;
        int    f1;
        int    f2;
        byte   c;
        logic  good;
        string line;
        string name;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("cannot open trace file %s", TRACE_FILE);
            n_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                n_lines++;
                c = (line.len() > 0) ? line.getc(0) : "#";
                // comments and blank lines
                if (c != "#" && c != "\n" && c != "\r" && c != " ") begin
                    f0 = 0;
                    f1 = 0;
                    f2 = 0;
                    name = "";
                    case (c)
                        "W":     good = ($sscanf(line, "W %h %h", f0, f1) == 2);
                        "I":     good = ($sscanf(line, "I %h", f0) == 1);
                        "R":     good = ($sscanf(line, "R %h %h %h", f0, f1, f2) == 3);
                        "T":     good = ($sscanf(line, "T %s", name) == 1);
                        default: good = 1'b0;
                    endcase
                    if (good) begin
                        tr_kind.push_back(c);
                        tr_f0.push_back(f0);
                        tr_f1.push_back(f1);
                        tr_f2.push_back(f2);
                        tr_name.push_back(name);
                    end else begin
                        $display("trace line %0d could not be read: %s", n_lines, line);
                        n_errors++;
                    end
                end
            end
            $fclose(fd);
            trace_loaded = (n_errors == 0);
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    // idle handshake state right after reset
    task automatic check_reset_state();
        @(negedge clk);
        n_checks++;
        if (cmd_ready !== 1'b1 || res_valid !== 1'b0) begin
            $display("after reset the core is not idle: cmd_ready=%b res_valid=%b",
                     cmd_ready, res_valid);
            n_errors++;
        end
        n_tests++;
        if (n_errors == 0) begin
            $display("test reset_state: ok");
        end else begin
            $display("test reset_state: %0d errors", n_errors);
        end
        @(posedge clk);
        #1;
    endtask

    // called 1 ns after a rising edge and returns the same way
    task automatic send_cmd(input cmd_t c);
        cmd = c;
        cmd_valid = 1'b1;
        @(negedge clk);
        while (!cmd_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    task automatic finish_test();
        result_t r;
        if (cur_test != "") begin
            // command done once the core is back in idle
            @(negedge clk);
            while (!cmd_ready) begin
                @(negedge clk);
            end
            while (exp_q.size() > 0) begin
                r = exp_q.pop_front();
                $display("expected result a=%h b=%h y=%h never arrived", r.a, r.b, r.y);
                n_errors++;
            end
            n_tests++;
            if (n_errors == test_err_start) begin
                $display("test %s: ok", cur_test);
            end else begin
                $display("test %s: %0d errors", cur_test, n_errors - test_err_start);
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_trace();
        cmd_t    c;
        result_t r;
        for (int i = 0; i < tr_kind.size(); i++) begin
            c = '0;
            case (tr_kind[i])
                "W": begin
                    c.kind = CMD_REG_WRITE;
                    c.reg_addr = reg_addr_t'(tr_f0[i]);
                    c.data = data_t'(tr_f1[i]);
                    send_cmd(c);
                end
                "I": begin
                    c.kind = CMD_INSTR;
                    c.instr = instr_t'(tr_f0[i]);
                    send_cmd(c);
                end
                "R": begin
                    r.a = data_t'(tr_f0[i]);
                    r.b = data_t'(tr_f1[i]);
                    r.y = data_t'(tr_f2[i]);
                    exp_q.push_back(r);
                end
                default: begin
                    finish_test();
                    cur_test = tr_name[i];
                    test_err_start = n_errors;
                end
            endcase
        end
        finish_test();
    endtask

    // random back-pressure on the result stream
    initial begin
        // first draw seeds the generator of this process
        res_ready = ($urandom(62358) % 4) != 0;
        forever begin
            @(posedge clk);
            #1;
            res_ready = ($urandom % 4) != 0;
        end
    end

    // a transfer sampled here completes on the next rising edge
    always @(negedge clk) begin
        if (!rst && res_valid === 1'b1 && res_ready === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("result a=%h b=%h y=%h arrived at %0t but none was expected",
                         res.a, res.b, res.y, $time);
                n_errors++;
            end else begin
                mon_exp = exp_q.pop_front();
                check_result(res, mon_exp);
            end
        end
    end

    initial begin
        wait (trace_loaded);
        limit_cycles = n_lines * CYCLES_PER_LINE;
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: run still busy after %0d clock cycles", limit_cycles);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        cmd = '0;
        cmd_valid = 1'b0;
        load_trace();
        if (trace_loaded) begin
            apply_reset();
            check_reset_state();
            run_trace();
        end
        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== logic/mini_core.sv ====
`timescale 1ns/10ps

module mini_core (
    input  logic              clk,
    input  logic              rst,
    input  core_pkg::cmd_t    cmd,
    input  logic              cmd_valid,
    output logic              cmd_ready,
    output core_pkg::result_t res,
    output logic              res_valid,
    input  logic              res_ready
);
    import isa_pkg::*;
    import core_pkg::*;

    rf_ctrl_t  rf_ctrl;
    mem_ctrl_t mem_ctrl;
    alu_op_e   alu_op;
    logic      alu_start;
    result_t   alu_res;
    data_t     cmd_data;
    data_t     rd_a;
    data_t     rd_b;
    data_t     mem_rdata;

    sequencer i_sequencer (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .alu_res   (alu_res),
        .res       (res),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .rf_ctrl   (rf_ctrl),
        .cmd_data  (cmd_data),
        .mem_ctrl  (mem_ctrl),
        .alu_op    (alu_op),
        .alu_start (alu_start)
    );

    register_file i_register_file (
        .clk       (clk),
        .rst       (rst),
        .rf_ctrl   (rf_ctrl),
        .alu_y     (alu_res.y),
        .mem_rdata (mem_rdata),
        .cmd_data  (cmd_data),
        .rd_a      (rd_a),
        .rd_b      (rd_b)
    );

    alu i_alu (
        .clk       (clk),
        .rst       (rst),
        .alu_start (alu_start),
        .alu_op    (alu_op),
        .rd_a      (rd_a),
        .rd_b      (rd_b),
        .alu_res   (alu_res)
    );

    // store data comes from read port a
    data_memory i_data_memory (
        .clk       (clk),
        .rst       (rst),
        .mem_ctrl  (mem_ctrl),
        .wdata     (rd_a),
        .mem_rdata (mem_rdata)
    );

endmodule

// ==== logic/data_memory.sv ====
`timescale 1ns/10ps

module data_memory (
    input  logic                clk,
    input  logic                rst,
    input  core_pkg::mem_ctrl_t mem_ctrl,
    input  isa_pkg::data_t      wdata,
    output isa_pkg::data_t      mem_rdata
);
    import isa_pkg::*;
    import core_pkg::*;

    data_t     mem [0:15];
    mem_addr_t addr;

    assign addr = mem_ctrl.addr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem       <= '{default: '0};
            mem_rdata <= '0;
        end else begin
            if (mem_ctrl.we) begin
                mem[addr] <= wdata;
            end
            // read data held until the next read
            if (mem_ctrl.re) begin
                mem_rdata <= mem[addr];
            end
        end
    end

    // sequencer issues load and store in separate commands
    a_no_rw_overlap: assert property (
        @(posedge clk) disable iff (rst)
        !(mem_ctrl.re && mem_ctrl.we)
    );

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/10ps

module alu (
    input  logic              clk,
    input  logic              rst,
    input  logic              alu_start,
    input  core_pkg::alu_op_e alu_op,
    input  isa_pkg::data_t    rd_a,
    input  isa_pkg::data_t    rd_b,
    output core_pkg::result_t alu_res
);
    import isa_pkg::*;
    import core_pkg::*;

    data_t y_next;

    // 4-bit wraparound, no carry or borrow kept
    always_comb begin
        if (alu_op == ALU_SUB) begin
            y_next = rd_a - rd_b;
        end else begin
            y_next = rd_a + rd_b;
        end
    end

    // operands go out with the result as one record
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            alu_res <= '0;
        end else if (alu_start) begin
            alu_res.a <= rd_a;
            alu_res.b <= rd_b;
            alu_res.y <= y_next;
        end
    end

    a_op_known: assert property (
        @(posedge clk) disable iff (rst)
        alu_start |-> !$isunknown(alu_op)
    );

endmodule

// ==== logic/register_file.sv ====
`timescale 1ns/10ps

module register_file (
    input  logic               clk,
    input  logic               rst,
    input  core_pkg::rf_ctrl_t rf_ctrl,
    input  isa_pkg::data_t     alu_y,
    input  isa_pkg::data_t     mem_rdata,
    input  isa_pkg::data_t     cmd_data,
    output isa_pkg::data_t     rd_a,
    output isa_pkg::data_t     rd_b
);
    import isa_pkg::*;
    import core_pkg::*;

    data_t regs [0:7];
    data_t wr_data;

    // writeback source select
    always_comb begin
        case (rf_ctrl.wb_src)
            WB_ALU:  wr_data = alu_y;
            WB_MEM:  wr_data = mem_rdata;
            default: wr_data = cmd_data;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            regs <= '{default: '0};
        end else if (rf_ctrl.wb_src != WB_NONE) begin
            regs[rf_ctrl.wr_addr] <= wr_data;
        end
    end

    // two asynchronous read ports
    assign rd_a = regs[rf_ctrl.rd_addr_a];
    assign rd_b = regs[rf_ctrl.rd_addr_b];

    a_wb_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(rf_ctrl.wb_src)
    );

endmodule

// ==== logic/sequencer.sv ====
`timescale 1ns/10ps

module sequencer (
    input  logic                clk,
    input  logic                rst,
    input  core_pkg::cmd_t      cmd,
    input  logic                cmd_valid,
    output logic                cmd_ready,
    input  core_pkg::result_t   alu_res,
    output core_pkg::result_t   res,
    output logic                res_valid,
    input  logic                res_ready,
    output core_pkg::rf_ctrl_t  rf_ctrl,
    output isa_pkg::data_t      cmd_data,
    output core_pkg::mem_ctrl_t mem_ctrl,
    output core_pkg::alu_op_e   alu_op,
    output logic                alu_start
);
    import isa_pkg::*;
    import core_pkg::*;

    seq_state_e state;
    seq_state_e state_next;
    cmd_t       cmd_q;
    result_t    res_q;
    opcode_e    opcode;
    logic       is_reg_write;
    logic       is_arith;

    assign opcode       = get_opcode(cmd_q.instr);
    assign is_reg_write = (cmd_q.kind == CMD_REG_WRITE);
    assign is_arith     = !is_reg_write && (opcode == ADD || opcode == SUB);

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                // register writes skip decode and execute
                if (cmd_valid) begin
                    if (cmd.kind == CMD_REG_WRITE) begin
                        state_next = WRITEBACK;
                    end else begin
                        state_next = DECODE;
                    end
                end
            end
            DECODE: begin
                case (opcode)
                    LOAD, STORE, SUB, ADD: state_next = EXEC;
                    default:               state_next = IDLE;
                endcase
            end
            EXEC: begin
                // store finishes with the memory write
                if (opcode == STORE) begin
                    state_next = IDLE;
                end else begin
                    state_next = WRITEBACK;
                end
            end
            WRITEBACK: begin
                if (is_arith) begin
                    state_next = RESULT;
                end else begin
                    state_next = IDLE;
                end
            end
            RESULT: begin
                if (res_ready) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // command and result holding registers
    always_ff @(posedge clk) begin
        if (state == IDLE && cmd_valid) begin
            cmd_q <= cmd;
        end
        if (state == WRITEBACK && is_arith) begin
            res_q <= alu_res;
        end
    end

    // store reads its source through port a, which also feeds memory wdata
    always_comb begin
        rf_ctrl.rd_addr_a = (opcode == STORE) ? get_ls_reg(cmd_q.instr) : get_src_a(cmd_q.instr);
        rf_ctrl.rd_addr_b = get_src_b(cmd_q.instr);
        rf_ctrl.wr_addr   = get_dst(cmd_q.instr);
        rf_ctrl.wb_src    = WB_NONE;
        if (state == WRITEBACK) begin
            if (is_reg_write) begin
                rf_ctrl.wr_addr = cmd_q.reg_addr;
                rf_ctrl.wb_src  = WB_CMD;
            end else if (opcode == LOAD) begin
                rf_ctrl.wr_addr = get_ls_reg(cmd_q.instr);
                rf_ctrl.wb_src  = WB_MEM;
            end else if (is_arith) begin
                rf_ctrl.wb_src  = WB_ALU;
            end
        end
    end

    assign mem_ctrl.re   = (state == EXEC) && (opcode == LOAD);
    assign mem_ctrl.we   = (state == EXEC) && (opcode == STORE);
    assign mem_ctrl.addr = get_mem_addr(cmd_q.instr);

    assign alu_op    = (opcode == SUB) ? ALU_SUB : ALU_ADD;
    assign alu_start = (state == EXEC) && is_arith;

    assign cmd_data  = cmd_q.data;
    assign cmd_ready = (state == IDLE);
    assign res_valid = (state == RESULT);
    assign res       = res_q;

    // result held under back-pressure
    a_res_stable: assert property (
        @(posedge clk) disable iff (rst)
        res_valid && !res_ready |=> res_valid && $stable(res)
    );

    // ready drops on the edge that takes a command
    a_ready_drop: assert property (
        @(posedge clk) disable iff (rst)
        cmd_valid && cmd_ready |=> !cmd_ready
    );

endmodule

// ==== logic/core_pkg.sv ====
package core_pkg;

    typedef enum logic {
        CMD_INSTR,
        CMD_REG_WRITE
    } cmd_kind_e;

    // reg_addr and data only matter for a register write
    typedef struct packed {
        cmd_kind_e          kind;
        isa_pkg::instr_t    instr;
        isa_pkg::reg_addr_t reg_addr;
        isa_pkg::data_t     data;
    } cmd_t;

    typedef struct packed {
        isa_pkg::data_t a;
        isa_pkg::data_t b;
        isa_pkg::data_t y;
    } result_t;

    typedef enum logic {
        ALU_ADD,
        ALU_SUB
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_NONE,
        WB_ALU,
        WB_MEM,
        WB_CMD
    } wb_src_e;

    typedef struct packed {
        isa_pkg::reg_addr_t rd_addr_a;
        isa_pkg::reg_addr_t rd_addr_b;
        isa_pkg::reg_addr_t wr_addr;
        wb_src_e            wb_src;
    } rf_ctrl_t;

    typedef struct packed {
        logic               re;
        logic               we;
        isa_pkg::mem_addr_t addr;
    } mem_ctrl_t;

    typedef enum logic [2:0] {
        IDLE,
        DECODE,
        EXEC,
        WRITEBACK,
        RESULT
    } seq_state_e;

endpackage

// ==== logic/isa_pkg.sv ====
package isa_pkg;

    // widths fixed by the 12-bit instruction word
    typedef logic [3:0]  data_t;
    typedef logic [2:0]  reg_addr_t;
    typedef logic [3:0]  mem_addr_t;
    typedef logic [11:0] instr_t;

    // values 4 to 7 are undefined and get ignored
    typedef enum logic [2:0] {
        LOAD  = 3'd0,
        STORE = 3'd1,
        SUB   = 3'd2,
        ADD   = 3'd3
    } opcode_e;

    function automatic opcode_e get_opcode(instr_t instr);
        return opcode_e'(instr[11:9]);
    endfunction

    // arithmetic format
    function automatic reg_addr_t get_dst(instr_t instr);
        return instr[8:6];
    endfunction

    function automatic reg_addr_t get_src_a(instr_t instr);
        return instr[5:3];
    endfunction

    function automatic reg_addr_t get_src_b(instr_t instr);
        return instr[2:0];
    endfunction

    // load/store format
    function automatic reg_addr_t get_ls_reg(instr_t instr);
        return instr[6:4];
    endfunction

    function automatic mem_addr_t get_mem_addr(instr_t instr);
        return instr[3:0];
    endfunction

endpackage
